/* Makefile */
SIM      = verilator
TOP      = game_tb
FILELIST = compile.f
FLAGS    = --binary --timing --assert -Wno-fatal
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

lint:
	$(SIM) --lint-only -Wall --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

/* compile.f */
+incdir+include
hw/game_pkg.sv
hw/level_fsm.sv
hw/spawn_scheduler.sv
hw/player_status.sv
hw/game_controller.sv
dv/game_assert.sv
dv/game_tb.sv

/* dv/game_assert.sv */
`timescale 1ns/100ps

module game_assert
	import game_pkg::*;
(
	input logic    clk,
	input logic    resetN,
	input logic    start_of_frame,
	input deploy_t deploy,
	input player_t player
);

	logic       step_d;      // frame step one cycle ago
	logic [7:0] last_shot;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			step_d <= 1'b0;
			last_shot <= 8'h80;   // slot 0 comes first
		end
		else begin
			step_d <= start_of_frame;
			if (step_d && deploy.shot != '0)
				last_shot <= deploy.shot;
		end
	end

	// deploy only moves on the cycle after a frame step
	a_deploy_hold: assert property (@(posedge clk) disable iff (!resetN)
		!$past(start_of_frame) |-> $stable(deploy))
		else $error("deploy changed away from a frame step");

	// each shot is one-hot and takes the slot after the last one
	a_shot_rotate: assert property (@(posedge clk) disable iff (!resetN)
		step_d && deploy.shot != '0 |-> deploy.shot == {last_shot[6:0], last_shot[7]})
		else $error("shot slot out of rotation");

	a_hearts_max: assert property (@(posedge clk) disable iff (!resetN)
		$past(player.hearts) == 2'd3 |-> player.hearts >= 2'd2)
		else $error("hearts wrapped past three");

endmodule

bind game_controller game_assert game_assert_i (
	.clk           (clk),
	.resetN        (resetN),
	.start_of_frame(start_of_frame),
	.deploy        (deploy),
	.player        (player)
);

/* dv/game_tb.sv */
`timescale 1ns/100ps
`include "game_macros.svh"

module game_tb
	import game_pkg::*;
();

	localparam int FRAME_LIMIT = 3000;   // tests run about 2000 frames

	logic       clk = 1'b0;
	logic       resetN, start_of_frame, shoot, god_mode, rapid_fire;
	logic       single_hit_pulse, pickup_hit, out_of_time;
	logic [7:0] random;
	logic [3:0] bird_alive;
	deploy_t    deploy;
	level_cfg_t cfg;
	bcd2_t      level_num, time_to_add;
	player_t    player;
	logic       add_time;

	integer seed = 32'hb2d1_2b89;
	int     errors = 0;
	int     frame_cnt = 0;

	int         m_level, m_pause, m_cool, m_slot, m_tcnt, m_tslot, m_pending;
	int         m_hearts, m_red, m_pu;
	bit         m_armed, m_start, m_active;
	logic [3:0] m_last, m_pwr;   // shield in bit 0 up to life in bit 3
	deploy_t    exp_deploy;
	bit         exp_add;

	game_controller dut_i (.*);

	always #50 clk = ~clk;

	always @(posedge clk)
		if (start_of_frame)
			frame_cnt <= frame_cnt + 1;

	function automatic int cap(input int v, input int lim);
		return (v < lim) ? v : lim;
	endfunction

	function automatic level_cfg_t cfg_for(input int lvl);
		level_cfg_t c;
		c.trees_to_add = 2'(cap(lvl, 3));
		c.tree_speed = 3'(cap(lvl, 7));
		c.bird_speed = 2'(cap((lvl - 1) / 2, 3));
		c.num_birds = 2'(cap(lvl, 4) - 1);
		c.bird_life = 4'(cap(lvl, 15));
		return c;
	endfunction

	function automatic void model_reset();
		m_level = 1;
		m_armed = 1'b0;
		m_pause = 0;
		m_start = 1'b1;   // level 1 goes out on the first frame
		m_last = 4'd0;
		m_cool = 0;
		m_slot = 0;
		m_tcnt = 0;
		m_tslot = 0;
		m_pending = 0;
		m_hearts = `GAME_START_HEARTS;
		m_active = 1'b1;
		m_red = 0;
		m_pu = 0;
		m_pwr = 4'd0;
	endfunction

	// game rules for one frame step
	function automatic void ref_frame(input logic shoot_i, god_i, rfire_i, hit_i, pick_i,
			oot_i, input logic [7:0] rnd_i, input logic [3:0] birds_i);
		bit         fire;
		bit         release_tree;
		bit         guarded;
		int         hearts_n;
		logic [3:0] pwr_n;
		exp_deploy = '0;
		fire = shoot_i && (m_cool == 0);
		release_tree = (m_tcnt == `GAME_TREE_WAIT - 1) && (m_pending > 0);
		if (m_cool > 0)
			m_cool--;
		if (fire) begin
			exp_deploy.shot[m_slot] = 1'b1;
			m_slot = (m_slot + 1) % `GAME_MAX_SHOTS;
			m_cool = (rfire_i || m_pwr[1]) ? `GAME_COOLDOWN_FAST : `GAME_COOLDOWN_SLOW;
		end
		m_tcnt = (m_tcnt + 1) % `GAME_TREE_WAIT;
		if (release_tree) begin
			exp_deploy.tree[m_tslot] = 1'b1;
			m_tslot = (m_tslot + 1) % `GAME_MAX_TREES;
			m_pending--;
		end
		if (m_start) begin
			exp_deploy.bird = 4'((1 << cap(m_level, 4)) - 1);
			exp_deploy.pickup = 1'b1;
			m_pending += cap(m_level, 3);
		end

		exp_add = (birds_i < m_last) && m_active;   // bird count dropped
		m_last = birds_i;
		m_start = (m_pause == 1) && (birds_i == 4'd0);
		if (m_pause > 0)
			m_pause--;
		if (m_armed && birds_i == 4'd0) begin
			m_armed = 1'b0;
			m_pause = `GAME_LEVEL_PAUSE;
			m_level = cap(m_level + 1, 99);
		end
		else if (birds_i != 4'd0)
			m_armed = 1'b1;

		guarded = (m_red > 0) || god_i || m_pwr[0];
		hearts_n = m_hearts;
		if (m_red > 0)
			m_red--;
		if (hit_i && !guarded && m_hearts > 0) begin
			hearts_n = m_hearts - 1;
			if (hearts_n == 0)
				m_active = 1'b0;
			else
				m_red = `GAME_RED_FRAMES;
		end
		if (oot_i)
			m_active = 1'b0;
		pwr_n = (m_pu == 0) ? 4'd0 : m_pwr;
		if (pick_i)
			pwr_n[rnd_i[5:4]] = 1'b1;
		if (m_pwr[3])
			pwr_n[3] = 1'b0;   // extra heart is used once
		if (m_pwr[3] && m_hearts < `GAME_START_HEARTS)
			hearts_n = m_hearts + 1;
		if (m_pu > 0)
			m_pu--;
		if (pick_i)
			m_pu = `GAME_POWERUP_FRAMES;
		m_hearts = hearts_n;
		m_pwr = pwr_n;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("ERR %0t %s got %0h exp %0h", $time, name, got, exp);
		end
	endtask

	initial begin
		player_t exp_player;
		forever begin
			@(posedge clk);
			if (resetN && start_of_frame) begin
				ref_frame(shoot, god_mode, rapid_fire, single_hit_pulse, pickup_hit,
					out_of_time, random, bird_alive);
				#50;
				check_value("add_time", add_time, exp_add);
				check_value("time_to_add", time_to_add, exp_add ? 8'h10 : 8'h00);
				#100;   // level_num settles a cycle after the step
				exp_player = '{hearts: 2'(m_hearts), red: m_red > 0, active: m_active,
					shield: god_mode || m_pwr[0], more_damage: m_pwr[2]};
				check_value("deploy", deploy, exp_deploy);
				check_value("cfg", cfg, cfg_for(m_level));
				check_value("level_num", level_num, {4'(m_level / 10), 4'(m_level % 10)});
				check_value("player", player, exp_player);
			end
		end
	end

	initial begin
		wait (frame_cnt >= FRAME_LIMIT);
		$display("frame limit of %0d reached before the tests finished", FRAME_LIMIT);
		$display("=== FAIL ===");
		$finish;
	end

	task automatic run_frames(input int n);
		repeat (n) begin
			start_of_frame = 1'b1;
			@(posedge clk);
			#10;
			start_of_frame = 1'b0;
			repeat (3) begin
				@(posedge clk);
				#10;
			end
		end
	endtask

	task automatic apply_reset();
		resetN = 1'b0;
		model_reset();
		repeat (3) @(posedge clk);
		#10;
		check_value("add_time", add_time, 1'b1);
		check_value("time_to_add", time_to_add, 8'h99);
		resetN = 1'b1;
		@(posedge clk);
		#10;
		check_value("add_time", add_time, 1'b0);   // load is taken once
	endtask

	task automatic grab_pickup(input logic [1:0] idx);
		random = 8'($random(seed));
		random[5:4] = idx;
		pickup_hit = 1'b1;
		run_frames(1);
		pickup_hit = 1'b0;
	endtask

	task automatic take_hit();
		single_hit_pulse = 1'b1;
		run_frames(1);
		single_hit_pulse = 1'b0;
	endtask

	task automatic clear_level();
		bird_alive = 4'd3;
		run_frames(3);
		bird_alive = 4'd1;   // two birds down, bonus
		run_frames(3);
		bird_alive = 4'd0;
		run_frames(110);
	endtask

	initial begin
		resetN = 1'b0;
		start_of_frame = 1'b0;
		shoot = 1'b0;
		god_mode = 1'b0;
		rapid_fire = 1'b0;
		single_hit_pulse = 1'b0;
		pickup_hit = 1'b0;
		out_of_time = 1'b0;
		random = 8'd0;
		bird_alive = 4'd0;
		apply_reset();
		run_frames(45);   // level 1 birds, then one tree
		shoot = 1'b1;
		run_frames(110);
		rapid_fire = 1'b1;
		run_frames(100);
		shoot = 1'b0;
		rapid_fire = 1'b0;
		run_frames(55);
		grab_pickup(2'd2);
		run_frames(205);
		grab_pickup(2'd1);   // rapid fire power-up
		shoot = 1'b1;
		run_frames(100);
		shoot = 1'b0;
		run_frames(110);
		grab_pickup(2'd0);
		take_hit();   // blocked by shield
		run_frames(205);
		take_hit();
		run_frames(10);
		take_hit();   // still red
		run_frames(60);
		god_mode = 1'b1;
		take_hit();
		god_mode = 1'b0;
		grab_pickup(2'd3);   // heart back
		run_frames(5);
		grab_pickup(2'd3);   // hearts already full
		run_frames(5);
		repeat (6) clear_level();
		repeat (40) begin
			bird_alive = 4'($random(seed));
			run_frames(1);
		end
		bird_alive = 4'd0;
		repeat (3) begin
			take_hit();
			run_frames(70);
		end
		bird_alive = 4'd2;
		run_frames(2);
		bird_alive = 4'd1;   // no bonus once inactive
		run_frames(2);
		bird_alive = 4'd0;
		apply_reset();
		out_of_time = 1'b1;
		run_frames(3);
		out_of_time = 1'b0;
		run_frames(5);
		$display("frames %0d, errors %0d", frame_cnt, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

/* hw/game_controller.sv */
`timescale 1ns/100ps
`include "game_macros.svh"

module game_controller
	import game_pkg::*;
(
	input  logic       clk,
	input  logic       resetN,
	input  logic       start_of_frame,
	input  logic       shoot,
	input  logic       god_mode,
	input  logic       rapid_fire,
	input  logic       single_hit_pulse,
	input  logic       pickup_hit,
	input  logic       out_of_time,
	input  logic [7:0] random,
	input  logic [3:0] bird_alive,
	output deploy_t    deploy,
	output level_cfg_t cfg,
	output bcd2_t      level_num,
	output player_t    player,
	output logic       add_time,
	output bcd2_t      time_to_add
);

	logic       level_up;
	logic       start_level;
	logic       rapid;
	logic       no_birds_yet;   // armed once birds appear
	logic [6:0] pause;
	logic [3:0] last_birds;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			add_time <= 1'b1;   // timer loads 99 after reset
			time_to_add <= '{tens: 4'd9, units: 4'd9};
			level_up <= 1'b0;
			start_level <= 1'b1;   // deploy level 1 on first frame
			no_birds_yet <= 1'b1;
			pause <= '0;
			last_birds <= '0;
		end
		else begin
			add_time <= 1'b0;
			time_to_add <= '0;
			level_up <= 1'b0;
			if (start_of_frame) begin
				start_level <= 1'b0;
				last_birds <= bird_alive;
				if (pause != '0)
					pause <= pause - 1'b1;

				if (bird_alive != 4'd0)
					no_birds_yet <= 1'b0;

				if (!no_birds_yet && bird_alive == 4'd0) begin   // level cleared
					level_up <= 1'b1;
					pause <= 7'(`GAME_LEVEL_PAUSE);
					no_birds_yet <= 1'b1;
				end

				if (pause == 7'd1 && bird_alive == 4'd0)
					start_level <= 1'b1;

				// bonus for each frame with fewer birds
				if (bird_alive < last_birds && player.active) begin
					add_time <= 1'b1;
					time_to_add <= '{tens: 4'd1, units: 4'd0};
				end
			end
		end
	end

	level_fsm level_fsm_i (
		.clk      (clk),
		.resetN   (resetN),
		.level_up (level_up),
		.cfg      (cfg),
		.level_num(level_num)
	);

	spawn_scheduler spawn_scheduler_i (
		.clk           (clk),
		.resetN        (resetN),
		.start_of_frame(start_of_frame),
		.shoot         (shoot),
		.start_level   (start_level),
		.rapid         (rapid),
		.cfg           (cfg),
		.deploy        (deploy)
	);

	player_status player_status_i (
		.clk             (clk),
		.resetN          (resetN),
		.start_of_frame  (start_of_frame),
		.single_hit_pulse(single_hit_pulse),
		.god_mode        (god_mode),
		.rapid_fire      (rapid_fire),
		.pickup_hit      (pickup_hit),
		.out_of_time     (out_of_time),
		.random          (random),
		.player          (player),
		.rapid           (rapid)
	);

endmodule

/* hw/game_pkg.sv */
package game_pkg;

	typedef struct packed {
		logic [1:0] trees_to_add;
		logic [2:0] tree_speed;
		logic [1:0] bird_speed;
		logic [1:0] num_birds;    // bird count minus one
		logic [3:0] bird_life;
	} level_cfg_t;

	typedef struct packed {
		logic [7:0]  shot;
		logic [15:0] tree;
		logic [3:0]  bird;
		logic        pickup;
	} deploy_t;

	// bit 0 is shield, bit 3 is life
	typedef struct packed {
		logic life;
		logic damage;
		logic rapid;
		logic shield;
	} powerup_t;

	typedef struct packed {
		logic [3:0] tens;
		logic [3:0] units;
	} bcd2_t;

	typedef struct packed {
		logic [1:0] hearts;
		logic       red;
		logic       active;
		logic       shield;
		logic       more_damage;
	} player_t;

endpackage

/* hw/level_fsm.sv */
`timescale 1ns/100ps
`include "game_macros.svh"

module level_fsm
	import game_pkg::*;
(
	input  logic       clk,
	input  logic       resetN,
	input  logic       level_up,
	output level_cfg_t cfg,
	output bcd2_t      level_num
);

	logic [6:0] lvl;        // binary copy of level_num
	logic       at_max;
	logic [6:0] lvl_next;
	bcd2_t      bcd_next;

	// every field is the level capped by its width
	function automatic level_cfg_t cfg_of(input logic [6:0] n);
		level_cfg_t c;
		logic [6:0] half;
		half = (n - 7'd1) >> 1;
		c.trees_to_add = (n > 7'd3) ? 2'd3 : n[1:0];
		c.tree_speed = (n > 7'd7) ? 3'd7 : n[2:0];
		c.bird_speed = (half > 7'd3) ? 2'd3 : half[1:0];
		c.num_birds = (n > 7'd3) ? 2'd3 : n[1:0] - 2'd1;
		c.bird_life = (n > 7'd15) ? 4'd15 : n[3:0];
		return c;
	endfunction

	assign at_max = (lvl == 7'd99);
	assign lvl_next = lvl + 7'd1;

	always_comb begin
		if (level_num.units == 4'd9) begin
			bcd_next.tens = level_num.tens + 4'd1;
			bcd_next.units = 4'd0;
		end
		else begin
			bcd_next.tens = level_num.tens;
			bcd_next.units = level_num.units + 4'd1;
		end
	end

	// cfg follows the next level so both appear together
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			lvl <= 7'd1;
			level_num <= '{tens: 4'd0, units: 4'd1};
			cfg <= cfg_of(7'd1);
		end
		else if (level_up && !at_max) begin
			lvl <= lvl_next;
			level_num <= bcd_next;
			cfg <= cfg_of(lvl_next);
		end
	end

endmodule

/* hw/player_status.sv */
`timescale 1ns/100ps
`include "game_macros.svh"

module player_status
	import game_pkg::*;
(
	input  logic       clk,
	input  logic       resetN,
	input  logic       start_of_frame,
	input  logic       single_hit_pulse,
	input  logic       god_mode,
	input  logic       rapid_fire,
	input  logic       pickup_hit,
	input  logic       out_of_time,
	input  logic [7:0] random,
	output player_t    player,
	output logic       rapid
);

	logic [1:0] hearts;
	logic       active;
	logic [6:0] red_cnt;
	logic [7:0] pu_cnt;      // power-up lifetime
	powerup_t   pwr;
	powerup_t   pwr_next;
	logic [3:0] pick_bit;
	logic       invincible;

	assign pick_bit = 4'b0001 << random[5:4];
	assign invincible = (red_cnt != '0) || god_mode || pwr.shield;
	assign rapid = rapid_fire || pwr.rapid;

	always_comb begin
		pwr_next = pwr;
		if (pu_cnt == '0)
			pwr_next = '0;   // lifetime over
		if (pickup_hit)
			pwr_next = pwr_next | pick_bit;
		if (pwr.life)
			pwr_next.life = 1'b0;   // extra heart is one shot
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			hearts <= 2'(`GAME_START_HEARTS);
			active <= 1'b1;
			red_cnt <= '0;
			pu_cnt <= '0;
			pwr <= '0;
		end
		else if (start_of_frame) begin
			if (red_cnt != '0)
				red_cnt <= red_cnt - 1'b1;
			if (pu_cnt != '0)
				pu_cnt <= pu_cnt - 1'b1;

			if (single_hit_pulse && !invincible && hearts != 2'd0) begin
				hearts <= hearts - 2'd1;
				if (hearts > 2'd1)
					red_cnt <= 7'(`GAME_RED_FRAMES);
				else
					active <= 1'b0;   // last heart gone
			end

			if (out_of_time)
				active <= 1'b0;

			if (pickup_hit)
				pu_cnt <= 8'(`GAME_POWERUP_FRAMES);
			pwr <= pwr_next;

			// life pickup overrides a hit in the same frame
			if (pwr.life && hearts < 2'(`GAME_START_HEARTS))
				hearts <= hearts + 2'd1;
		end
	end

	assign player = '{
		hearts: hearts,
		red: (red_cnt != '0),
		active: active,
		shield: god_mode || pwr.shield,
		more_damage: pwr.damage
	};

endmodule

/* hw/spawn_scheduler.sv */
`timescale 1ns/100ps
`include "game_macros.svh"

module spawn_scheduler
	import game_pkg::*;
(
	input  logic       clk,
	input  logic       resetN,
	input  logic       start_of_frame,
	input  logic       shoot,
	input  logic       start_level,
	input  logic       rapid,
	input  level_cfg_t cfg,
	output deploy_t    deploy
);

	localparam int SHOT_W = $clog2(`GAME_MAX_SHOTS);
	localparam int TREE_W = $clog2(`GAME_MAX_TREES);
	localparam int WAIT_W = $clog2(`GAME_TREE_WAIT);
	localparam int CD_W = $clog2(`GAME_COOLDOWN_SLOW + 1);

	logic [SHOT_W-1:0] shot_slot;
	logic [TREE_W-1:0] tree_slot;
	logic [CD_W-1:0]   cooldown;
	logic [WAIT_W-1:0] tree_cnt;
	logic [5:0]        pending;     // trees still to release
	logic              fire;
	logic              tree_release;
	logic [1:0]        trees_in;
	logic [CD_W-1:0]   cooldown_load;

	assign fire = shoot && (cooldown == '0);
	assign tree_release = (tree_cnt == WAIT_W'(`GAME_TREE_WAIT - 1)) && (pending != '0);
	assign trees_in = start_level ? cfg.trees_to_add : 2'd0;
	assign cooldown_load = rapid ? CD_W'(`GAME_COOLDOWN_FAST) : CD_W'(`GAME_COOLDOWN_SLOW);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			deploy <= '0;
			shot_slot <= '0;
			tree_slot <= '0;
			cooldown <= '0;
			tree_cnt <= '0;
			pending <= '0;
		end
		else if (start_of_frame) begin
			deploy <= '0;   // pulses last one frame
			if (cooldown != '0)
				cooldown <= cooldown - 1'b1;

			if (fire) begin
				deploy.shot[shot_slot] <= 1'b1;
				shot_slot <= shot_slot + 1'b1;   // wraps at 8
				cooldown <= cooldown_load;
			end

			// free running release pacing
			if (tree_cnt == WAIT_W'(`GAME_TREE_WAIT - 1))
				tree_cnt <= '0;
			else
				tree_cnt <= tree_cnt + 1'b1;

			if (tree_release) begin
				deploy.tree[tree_slot] <= 1'b1;
				tree_slot <= tree_slot + 1'b1;
			end
			pending <= pending + 6'(trees_in) - 6'(tree_release);

			if (start_level) begin
				for (int i = 0; i < 4; i++) begin
					deploy.bird[i] <= (i <= int'(cfg.num_birds));
				end
				deploy.pickup <= 1'b1;
			end
		end
	end

endmodule

/* include/game_macros.svh */
`ifndef GAME_MACROS_SVH
`define GAME_MACROS_SVH

// slot counts
`define GAME_MAX_SHOTS 8
`define GAME_MAX_TREES 16

// frames between shots
`define GAME_COOLDOWN_SLOW 50
`define GAME_COOLDOWN_FAST 20

`define GAME_TREE_WAIT 40      // frames between tree releases
`define GAME_RED_FRAMES 64     // damage flash
`define GAME_POWERUP_FRAMES 200
`define GAME_LEVEL_PAUSE 100   // level end to next deployment

`define GAME_START_HEARTS 3

`endif
